/* rtl/phy_test_pkg.sv */
////////////////////////////////////////////////////////////
// PHY self-test shared definitions
// Payload patterns, FIFO word layout, state encodings and
// the APB register map of one port group
////////////////////////////////////////////////////////////

package phy_test_pkg;

   // Payload patterns, in the order the source walks them
   typedef enum logic [1:0] {
      PAT_ZEROS,
      PAT_ONES,
      PAT_ALT,
      PAT_INC
   } pat_t;

   localparam int NUM_PATTERNS = 4;

   // FIFO word is a control nibble over 32 data bits
   localparam int         FIFO_W    = 36;
   localparam logic [3:0] CTRL_HDR  = 4'h8;
   localparam logic [3:0] CTRL_LAST = 4'h1;
   localparam logic [3:0] CTRL_NONE = 4'h0;

   typedef enum logic [2:0] {
      RUN_IDLE,
      RUN_RESTART,
      RUN_TX,
      RUN_DRAIN,
      RUN_DONE
   } run_state_t;

   typedef enum logic [1:0] {
      SRC_IDLE,
      SRC_HDR,
      SRC_PAY,
      SRC_DONE
   } src_state_t;

   typedef enum logic {
      CMP_HUNT,
      CMP_PAY
   } cmp_state_t;

   ////////////////////////////////////////////////////////////
   // Register offsets
   ////////////////////////////////////////////////////////////
   localparam logic [7:0] REG_CTRL      = 8'h00;
   localparam logic [7:0] REG_PKT_WORDS = 8'h04;
   localparam logic [7:0] REG_ITERS     = 8'h08;
   localparam logic [7:0] REG_INIT_SEQ  = 8'h0C;
   localparam logic [7:0] REG_STATUS    = 8'h10;
   localparam logic [7:0] REG_TX_PKTS   = 8'h14;
   localparam logic [7:0] REG_GOOD_PKTS = 8'h18;
   localparam logic [7:0] REG_ERR_PKTS  = 8'h1C;
   localparam logic [7:0] REG_LAST_SEQ  = 8'h20;

   // Payload word at a given index within the packet
   function automatic logic [31:0] pat_word(pat_t p, logic [7:0] idx);
      logic [31:0] w;
      case (p)
         PAT_ZEROS: w = 32'h0000_0000;
         PAT_ONES:  w = 32'hffff_ffff;
         PAT_ALT:   w = idx[0] ? 32'haaaa_aaaa : 32'h5555_5555;
         default:   w = {24'h0, idx};
      endcase
      return w;
   endfunction

   // Next enabled code above cur, wrapping to the lowest one
   function automatic pat_t next_pat(logic [NUM_PATTERNS-1:0] en, pat_t cur);
      pat_t       nxt;
      logic       found;
      logic [1:0] code;
      nxt   = cur;
      found = 1'b0;
      for (int i = 1; i <= NUM_PATTERNS; i++)
      begin
         code = 2'(int'(cur) + i);
         if (en[code] && !found)
         begin
            nxt   = pat_t'(code);
            found = 1'b1;
         end
      end
      return nxt;
   endfunction

endpackage

/* rtl/phy_test_ifs.sv */
////////////////////////////////////////////////////////////
// Configuration and status bundles of the port group
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

interface phy_test_cfg_if
   import phy_test_pkg::*;
#(
   parameter int SEQ_W = 16
);
   logic [NUM_PATTERNS-1:0] pat_en;
   logic [7:0]              pkt_words;
   logic [15:0]             num_iters;
   logic [SEQ_W-1:0]        init_seq;

   modport regs (output pat_en, pkt_words, num_iters, init_seq);
   modport blk  (input  pat_en, pkt_words, num_iters, init_seq);
endinterface

interface phy_test_stat_if #(
   parameter int SEQ_W = 16
);
   logic [31:0]      tx_pkts;
   logic [31:0]      good_cnt;
   logic [31:0]      err_cnt;
   logic             locked;
   logic [SEQ_W-1:0] last_seq;

   modport cmp (output good_cnt, err_cnt, locked, last_seq);
   modport src (output tx_pkts);
   modport mon (input  tx_pkts, good_cnt, err_cnt, locked, last_seq);
endinterface

/* rtl/phy_test_pktsrc.sv */
////////////////////////////////////////////////////////////
// Test packet source
// Writes header plus pattern payload words into the
// transmit FIFO, one pass over the enabled patterns per
// iteration
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phy_test_pktsrc
   import phy_test_pkg::*;
#(
   parameter int         SEQ_W   = 16,
   parameter logic [2:0] PORT_ID = 3'd0
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              restart,
   input  logic              go,
   phy_test_cfg_if.blk       cfg,
   phy_test_stat_if.src      stat,
   output logic [FIFO_W-1:0] tx_data,
   output logic              tx_wr_en,
   input  logic              tx_almost_full,
   output logic              done
);

   src_state_t       state;
   pat_t             pat;
   pat_t             pat_nxt;
   logic [7:0]       word_idx;
   logic [15:0]      iter_cnt;
   logic [SEQ_W-1:0] seq;
   logic             last_word;
   logic [31:0]      hdr_word;

   assign pat_nxt   = next_pat(cfg.pat_en, pat);
   assign last_word = (word_idx == cfg.pkt_words - 8'd1);
   assign hdr_word  = {PORT_ID, 3'b000, pat, 8'h00, 16'(seq)};
   assign done      = (state == SRC_DONE);

   // Header waits for room, payload then streams back to back
   always_comb
   begin
      tx_wr_en = 1'b0;
      tx_data  = {last_word ? CTRL_LAST : CTRL_NONE, pat_word(pat, word_idx)};
      if (state == SRC_HDR)
      begin
         tx_wr_en = ~tx_almost_full;
         tx_data  = {CTRL_HDR, hdr_word};
      end
      else if (state == SRC_PAY)
         tx_wr_en = 1'b1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state        <= SRC_IDLE;
         pat          <= PAT_ZEROS;
         word_idx     <= '0;
         iter_cnt     <= '0;
         seq          <= '0;
         stat.tx_pkts <= '0;
      end
      else if (restart)
      begin
         state        <= SRC_IDLE;
         word_idx     <= '0;
         iter_cnt     <= '0;
         stat.tx_pkts <= '0;
      end
      else
      begin
         case (state)
            SRC_IDLE:
               if (go)
               begin
                  pat      <= next_pat(cfg.pat_en, PAT_INC);
                  seq      <= cfg.init_seq;
                  iter_cnt <= '0;
                  if (cfg.pat_en == '0 || cfg.num_iters == '0)
                     state <= SRC_DONE;
                  else
                     state <= SRC_HDR;
               end
            SRC_HDR:
               if (!tx_almost_full)
               begin
                  word_idx <= 8'd1;
                  state    <= SRC_PAY;
               end
            SRC_PAY:
            begin
               word_idx <= word_idx + 8'd1;
               if (last_word)
               begin
                  stat.tx_pkts <= stat.tx_pkts + 32'd1;
                  seq          <= seq + 1'b1;
                  pat          <= pat_nxt;
                  state        <= SRC_HDR;
                  // Wrapped to the lowest code, so one iteration is over
                  if (pat_nxt <= pat)
                  begin
                     iter_cnt <= iter_cnt + 16'd1;
                     if (iter_cnt + 16'd1 == cfg.num_iters)
                        state <= SRC_DONE;
                  end
               end
            end
            default: ;
         endcase
      end
   end

endmodule

/* rtl/phy_test_pktcmp.sv */
////////////////////////////////////////////////////////////
// Looped-back packet comparator
// Locks on the first header, then checks sequence, pattern
// order, port and payload, and counts good and bad packets
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phy_test_pktcmp
   import phy_test_pkg::*;
#(
   parameter int         SEQ_W   = 16,
   parameter logic [2:0] PORT_ID = 3'd0
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              restart,
   phy_test_cfg_if.blk       cfg,
   phy_test_stat_if.cmp      stat,
   input  logic [FIFO_W-1:0] rx_data,
   output logic              rx_rd_en,
   input  logic              rx_almost_empty
);

   cmp_state_t       state;
   logic             rd_vld;
   logic [3:0]       ctrl;
   logic [31:0]      data;
   logic             is_hdr;
   pat_t             rx_pat;
   logic [SEQ_W-1:0] rx_seq;
   logic             hdr_ok;
   logic             word_bad;
   pat_t             cur_pat;
   pat_t             exp_pat;
   logic [SEQ_W-1:0] exp_seq;
   logic [7:0]       word_idx;
   logic             pkt_bad;
   logic             verdict_vld;
   logic             verdict_bad;

   assign rx_rd_en = ~rx_almost_empty;

   assign ctrl   = rx_data[FIFO_W-1 -: 4];
   assign data   = rx_data[31:0];
   assign is_hdr = (ctrl == CTRL_HDR);
   assign rx_pat = pat_t'(data[25:24]);
   assign rx_seq = data[SEQ_W-1:0];

   // First header is taken as it comes
   assign hdr_ok = !stat.locked ||
                   (rx_seq == exp_seq && rx_pat == exp_pat && data[31:29] == PORT_ID);

   // Payload compare, and the closing word must sit at pkt_words - 1
   assign word_bad = (data != pat_word(cur_pat, word_idx)) ||
                     ((ctrl == CTRL_LAST) != (word_idx == cfg.pkt_words - 8'd1));

   ////////////////////////////////////////////////////////////
   // Expected stream, rebuilt from each received header
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk)
   begin
      if (rd_vld && is_hdr)
      begin
         cur_pat  <= rx_pat;
         exp_pat  <= next_pat(cfg.pat_en, rx_pat);
         exp_seq  <= rx_seq + 1'b1;
         word_idx <= 8'd1;
      end
      else if (rd_vld)
         word_idx <= word_idx + 8'd1;

      if (rd_vld && ctrl == CTRL_LAST)
         verdict_bad <= pkt_bad | word_bad;
   end

   ////////////////////////////////////////////////////////////
   // Packet tracking and counters
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         rd_vld        <= 1'b0;
         state         <= CMP_HUNT;
         pkt_bad       <= 1'b0;
         verdict_vld   <= 1'b0;
         stat.locked   <= 1'b0;
         stat.last_seq <= '0;
         stat.good_cnt <= '0;
         stat.err_cnt  <= '0;
      end
      else
      begin
         // FIFO read latency of one
         rd_vld      <= rx_rd_en;
         verdict_vld <= 1'b0;
         if (restart)
         begin
            state         <= CMP_HUNT;
            pkt_bad       <= 1'b0;
            stat.locked   <= 1'b0;
            stat.last_seq <= '0;
            stat.good_cnt <= '0;
            stat.err_cnt  <= '0;
         end
         else
         begin
            if (verdict_vld && verdict_bad)
               stat.err_cnt <= stat.err_cnt + 32'd1;
            else if (verdict_vld)
               stat.good_cnt <= stat.good_cnt + 32'd1;

            if (rd_vld && is_hdr)
            begin
               state         <= CMP_PAY;
               pkt_bad       <= ~hdr_ok;
               stat.locked   <= 1'b1;
               stat.last_seq <= rx_seq;
            end
            else if (rd_vld && state == CMP_PAY)
            begin
               if (word_bad)
                  pkt_bad <= 1'b1;
               if (ctrl == CTRL_LAST)
               begin
                  verdict_vld <= 1'b1;
                  state       <= CMP_HUNT;
               end
            end
         end
      end
   end

endmodule

/* rtl/phy_test_port_ctrl.sv */
////////////////////////////////////////////////////////////
// Run controller
// Restart, transmit, drain with timeout, then done and the
// pass verdict
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phy_test_port_ctrl
   import phy_test_pkg::*;
#(
   parameter int DRAIN_TIMEOUT = 512
)
(
   input  logic          clk,
   input  logic          rst_n,
   input  logic          start,
   phy_test_stat_if.mon  stat,
   phy_test_cfg_if.blk   cfg,
   output logic          restart,
   output logic          src_go,
   input  logic          src_done,
   output logic          busy,
   output logic          done,
   output logic          pass
);

   localparam int DW = $clog2(DRAIN_TIMEOUT + 1);

   run_state_t  state;
   logic [DW-1:0] drain_cnt;
   logic [31:0] exp_total;
   logic [31:0] rx_total;
   logic        reached;

   // Packets expected over the whole run
   assign exp_total = 32'(cfg.num_iters) * 32'($countones(cfg.pat_en));
   assign rx_total  = stat.good_cnt + stat.err_cnt;
   assign reached   = (rx_total == exp_total);

   assign restart = (state == RUN_RESTART);
   assign busy    = (state inside {RUN_RESTART, RUN_TX, RUN_DRAIN});
   assign done    = (state == RUN_DONE);

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state     <= RUN_IDLE;
         src_go    <= 1'b0;
         drain_cnt <= '0;
         pass      <= 1'b0;
      end
      else
      begin
         src_go <= 1'b0;
         case (state)
            RUN_IDLE, RUN_DONE:
               if (start)
               begin
                  state <= RUN_RESTART;
                  pass  <= 1'b0;
               end
            RUN_RESTART:
            begin
               state  <= RUN_TX;
               src_go <= 1'b1;
            end
            RUN_TX:
               if (src_done)
               begin
                  state     <= RUN_DRAIN;
                  drain_cnt <= '0;
               end
            RUN_DRAIN:
               if (reached || drain_cnt == DW'(DRAIN_TIMEOUT - 1))
               begin
                  state <= RUN_DONE;
                  pass  <= reached && (stat.err_cnt == 32'd0);
               end
               else
                  drain_cnt <= drain_cnt + 1'b1;
            default:
               state <= RUN_IDLE;
         endcase
      end
   end

endmodule

/* rtl/phy_test_apb_regs.sv */
////////////////////////////////////////////////////////////
// APB register block
// Configuration, start pulse, status and counters, with
// one wait state on every access
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phy_test_apb_regs
   import phy_test_pkg::*;
#(
   parameter int SEQ_W = 16
)
(
   input  logic         clk,
   input  logic         rst_n,
   input  logic         psel,
   input  logic         penable,
   input  logic         pwrite,
   input  logic [7:0]   paddr,
   input  logic [31:0]  pwdata,
   output logic [31:0]  prdata,
   output logic         pready,
   output logic         pslverr,
   phy_test_cfg_if.regs cfg,
   phy_test_stat_if.mon stat,
   input  logic         busy,
   input  logic         done,
   input  logic         pass,
   output logic         start
);

   logic        access;
   logic        mapped;
   logic [31:0] rd_mux;

   // First access cycle, pready follows in the next one
   assign access = psel & penable & ~pready;

   always_comb
   begin
      mapped = 1'b1;
      case (paddr)
         REG_CTRL:      rd_mux = 32'({cfg.pat_en, 8'h00});
         REG_PKT_WORDS: rd_mux = {24'h0, cfg.pkt_words};
         REG_ITERS:     rd_mux = {16'h0, cfg.num_iters};
         REG_INIT_SEQ:  rd_mux = 32'(cfg.init_seq);
         REG_STATUS:    rd_mux = {28'h0, stat.locked, pass, done, busy};
         REG_TX_PKTS:   rd_mux = stat.tx_pkts;
         REG_GOOD_PKTS: rd_mux = stat.good_cnt;
         REG_ERR_PKTS:  rd_mux = stat.err_cnt;
         REG_LAST_SEQ:  rd_mux = 32'(stat.last_seq);
         default:
         begin
            rd_mux = '0;
            mapped = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pready        <= 1'b0;
         pslverr       <= 1'b0;
         prdata        <= '0;
         start         <= 1'b0;
         cfg.pat_en    <= '1;
         cfg.pkt_words <= 8'd16;
         cfg.num_iters <= 16'd1;
         cfg.init_seq  <= '0;
      end
      else
      begin
         pready <= access;
         start  <= 1'b0;
         if (access)
         begin
            pslverr <= ~mapped;
            prdata  <= pwrite ? 32'h0 : rd_mux;
            if (pwrite)
            begin
               case (paddr)
                  REG_CTRL:
                  begin
                     start      <= pwdata[0];
                     cfg.pat_en <= pwdata[8 +: NUM_PATTERNS];
                  end
                  // Shortest packet is a header and one payload word
                  REG_PKT_WORDS:
                     cfg.pkt_words <= (pwdata[7:0] < 8'd2) ? 8'd2 : pwdata[7:0];
                  REG_ITERS:    cfg.num_iters <= pwdata[15:0];
                  REG_INIT_SEQ: cfg.init_seq  <= pwdata[SEQ_W-1:0];
                  default: ;
               endcase
            end
         end
      end
   end

endmodule

/* rtl/phy_test_port_grp.sv */
////////////////////////////////////////////////////////////
// PHY self-test port group
// APB registers, run controller, packet source and packet
// comparator for one port
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phy_test_port_grp
   import phy_test_pkg::*;
#(
   parameter int         SEQ_W         = 16,
   parameter int         DRAIN_TIMEOUT = 512,
   parameter logic [2:0] PORT_ID       = 3'd0
)
(
   input  logic              clk,
   input  logic              rst_n,
   // APB
   input  logic              psel,
   input  logic              penable,
   input  logic              pwrite,
   input  logic [7:0]        paddr,
   input  logic [31:0]       pwdata,
   output logic [31:0]       prdata,
   output logic              pready,
   output logic              pslverr,
   // Transmit FIFO
   output logic [FIFO_W-1:0] tx_data,
   output logic              tx_wr_en,
   input  logic              tx_almost_full,
   // Receive FIFO
   input  logic [FIFO_W-1:0] rx_data,
   output logic              rx_rd_en,
   input  logic              rx_almost_empty,
   // Status pins
   output logic              busy,
   output logic              done,
   output logic              pass
);

   logic start;
   logic restart;
   logic src_go;
   logic src_done;

   phy_test_cfg_if  #(.SEQ_W(SEQ_W)) cfg_i ();
   phy_test_stat_if #(.SEQ_W(SEQ_W)) stat_i ();

   phy_test_apb_regs #(.SEQ_W(SEQ_W)) regs_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr),
      .cfg     (cfg_i.regs),
      .stat    (stat_i.mon),
      .busy    (busy),
      .done    (done),
      .pass    (pass),
      .start   (start)
   );

   phy_test_port_ctrl #(.DRAIN_TIMEOUT(DRAIN_TIMEOUT)) ctrl_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .start    (start),
      .stat     (stat_i.mon),
      .cfg      (cfg_i.blk),
      .restart  (restart),
      .src_go   (src_go),
      .src_done (src_done),
      .busy     (busy),
      .done     (done),
      .pass     (pass)
   );

   phy_test_pktsrc #(.SEQ_W(SEQ_W), .PORT_ID(PORT_ID)) src_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .restart        (restart),
      .go             (src_go),
      .cfg            (cfg_i.blk),
      .stat           (stat_i.src),
      .tx_data        (tx_data),
      .tx_wr_en       (tx_wr_en),
      .tx_almost_full (tx_almost_full),
      .done           (src_done)
   );

   phy_test_pktcmp #(.SEQ_W(SEQ_W), .PORT_ID(PORT_ID)) cmp_i (
      .clk             (clk),
      .rst_n           (rst_n),
      .restart         (restart),
      .cfg             (cfg_i.blk),
      .stat            (stat_i.cmp),
      .rx_data         (rx_data),
      .rx_rd_en        (rx_rd_en),
      .rx_almost_empty (rx_almost_empty)
   );

endmodule

/* dv/phy_test_assert.sv */
////////////////////////////////////////////////////////////
// Port group assertions
// FIFO flow control, APB response and restart width
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phy_test_assert
   import phy_test_pkg::*;
(
   input logic              clk,
   input logic              rst_n,
   input logic [FIFO_W-1:0] tx_data,
   input logic              tx_wr_en,
   input logic              tx_almost_full,
   input logic              rx_rd_en,
   input logic              rx_almost_empty,
   input logic              pready,
   input logic              restart
);

   // A header opens a packet
   hdr_room: assert property (@(posedge clk) disable iff (!rst_n)
      (tx_wr_en && tx_data[FIFO_W-1 -: 4] == CTRL_HDR) |-> !tx_almost_full)
      else $error("packet started while tx_almost_full was high");

   rd_empty: assert property (@(posedge clk) disable iff (!rst_n)
      rx_rd_en |-> !rx_almost_empty)
      else $error("rx_rd_en high while rx_almost_empty was high");

   ready_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      pready |=> !pready)
      else $error("pready lasted more than one cycle");

   restart_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      restart |=> !restart)
      else $error("restart lasted more than one cycle");

endmodule

bind phy_test_port_grp phy_test_assert assert_i (
   .clk             (clk),
   .rst_n           (rst_n),
   .tx_data         (tx_data),
   .tx_wr_en        (tx_wr_en),
   .tx_almost_full  (tx_almost_full),
   .rx_rd_en        (rx_rd_en),
   .rx_almost_empty (rx_almost_empty),
   .pready          (pready),
   .restart         (restart)
);

/* dv/phy_test_tb.sv */
////////////////////////////////////////////////////////////
// Port group testbench
// FIFO loopback model with error injection, APB access and
// per-test checks from the pattern table
////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module phy_test_tb
   import phy_test_pkg::*;
();

   localparam int DRAIN     = 512;
   localparam int MAX_TESTS = 16;
   localparam int FIELDS    = 10;

   logic              clk;
   logic              rst_n;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [7:0]        paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;
   logic [FIFO_W-1:0] tx_data;
   logic              tx_wr_en;
   logic              tx_almost_full;
   logic [FIFO_W-1:0] rx_data;
   logic              rx_rd_en;
   logic              rx_almost_empty;
   logic              busy;
   logic              done;
   logic              pass;

   logic [31:0]       tv [0:MAX_TESTS*FIELDS-1];
   logic [FIFO_W-1:0] fifo_q [$];
   int                mode;
   int                inj_idx;
   int                hdr_cnt;
   int                hdr_idx;
   int                wdx;
   int                errors;
   int                test_errs;
   int                wd_cycles;

   phy_test_port_grp #(.DRAIN_TIMEOUT(DRAIN), .PORT_ID(3'd3)) dut_i (.*);

   always #4 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Loopback FIFO, read latency of one
   ////////////////////////////////////////////////////////////
   initial
   begin
      logic              wr;
      logic              rd;
      logic              keep;
      logic [FIFO_W-1:0] w;
      // Throttle gaps are drawn in this process
      void'($urandom(32'hf4f1_97f0));
      forever
      begin
         @(negedge clk);
         wr = tx_wr_en;
         rd = rx_rd_en;
         w  = tx_data;
         @(posedge clk);
         #1;
         if (rd && fifo_q.size() > 0)
            rx_data = fifo_q.pop_front();
         if (wr)
         begin
            if (w[FIFO_W-1 -: 4] == CTRL_HDR)
            begin
               hdr_idx = hdr_cnt;
               hdr_cnt++;
               wdx = 0;
            end
            else
               wdx++;
            keep = !(mode == 2 && hdr_idx == inj_idx);
            // Flip one payload bit of the chosen packet
            if (mode == 1 && hdr_idx == inj_idx && wdx == 1)
               w[0] = ~w[0];
            if (keep)
               fifo_q.push_back(w);
         end
         rx_almost_empty = (fifo_q.size() == 0);
         tx_almost_full  = (mode == 3) ? ($urandom_range(0, 2) == 0) : 1'b0;
      end
   end

   task automatic apb_access(input logic wr, input logic [7:0] addr,
                             input logic [31:0] wdata,
                             output logic [31:0] rdata, output logic err);
      @(posedge clk);
      #1;
      psel    = 1'b1;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge clk);
      #1;
      penable = 1'b1;
      @(negedge clk);
      while (pready !== 1'b1)
         @(negedge clk);
      rdata = prdata;
      err   = pslverr;
      @(posedge clk);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] rd;
      logic        err;
      apb_access(1'b1, addr, data, rd, err);
      if (err)
      begin
         $display("Write to offset 0x%02h was refused with pslverr", addr);
         errors++;
         test_errs++;
      end
   endtask

   task automatic apb_read(input logic [7:0] addr, output logic [31:0] data);
      logic err;
      apb_access(1'b0, addr, 32'h0, data, err);
      if (err)
      begin
         $display("Read from offset 0x%02h was refused with pslverr", addr);
         errors++;
         test_errs++;
      end
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("MISMATCH %s got 0x%08h expected 0x%08h", name, got, exp);
         errors++;
         test_errs++;
      end
   endtask

   function automatic int count_bits(input logic [31:0] v);
      int n;
      n = 0;
      for (int i = 0; i < NUM_PATTERNS; i++)
         n += int'(v[i]);
      return n;
   endfunction

   task automatic check_regs();
      logic [31:0] rd;
      logic        err;
      test_errs = 0;
      apb_write(REG_PKT_WORDS, 32'h0000_0033);
      apb_write(REG_ITERS, 32'h0000_0a5c);
      apb_write(REG_INIT_SEQ, 32'h0000_c3a1);
      apb_write(REG_CTRL, 32'h0000_0900);
      apb_read(REG_PKT_WORDS, rd);
      check_val("PKT_WORDS", rd, 32'h0000_0033);
      apb_read(REG_ITERS, rd);
      check_val("ITERS", rd, 32'h0000_0a5c);
      apb_read(REG_INIT_SEQ, rd);
      check_val("INIT_SEQ", rd, 32'h0000_c3a1);
      apb_read(REG_CTRL, rd);
      check_val("CTRL", rd, 32'h0000_0900);
      apb_access(1'b0, 8'h24, 32'h0, rd, err);
      check_val("unmapped prdata", rd, 32'h0);
      check_val("unmapped pslverr", {31'h0, err}, 32'h1);
      apb_access(1'b1, 8'h28, 32'hffff_ffff, rd, err);
      check_val("unmapped write pslverr", {31'h0, err}, 32'h1);
      apb_read(REG_PKT_WORDS, rd);
      check_val("PKT_WORDS after unmapped write", rd, 32'h0000_0033);
      $display("test regs: %s", (test_errs == 0) ? "ok" : "FAILED");
   endtask

   task automatic run_test(input int t);
      int          base;
      int          total;
      logic [31:0] rd;
      base      = t * FIELDS;
      test_errs = 0;
      total     = int'(tv[base+2]) * count_bits(tv[base]);
      hdr_cnt   = 0;
      mode      = int'(tv[base+4]);
      inj_idx   = int'(tv[base+5]);
      apb_write(REG_PKT_WORDS, tv[base+1]);
      apb_write(REG_ITERS, tv[base+2]);
      apb_write(REG_INIT_SEQ, tv[base+3]);
      apb_write(REG_CTRL, (tv[base] << 8) | 32'h1);
      // Previous done clears on restart, then wait for the new one
      while (done !== 1'b0)
         @(negedge clk);
      // Run under way from the restart cycle on
      check_val("busy", {31'h0, busy}, 32'h1);
      while (done !== 1'b1)
         @(negedge clk);
      check_val("pass", {31'h0, pass}, tv[base+6]);
      check_val("busy", {31'h0, busy}, 32'h0);
      apb_read(REG_STATUS, rd);
      check_val("STATUS", rd & 32'hf, {28'h0, total != 0, tv[base+6][0], 2'b10});
      apb_read(REG_TX_PKTS, rd);
      check_val("TX_PKTS", rd, 32'(total));
      apb_read(REG_GOOD_PKTS, rd);
      check_val("GOOD_PKTS", rd, tv[base+7]);
      if (mode == 0 || mode == 3)
         check_val("GOOD_PKTS vs total", rd, 32'(total));
      apb_read(REG_ERR_PKTS, rd);
      check_val("ERR_PKTS", rd, tv[base+8]);
      apb_read(REG_LAST_SEQ, rd);
      check_val("LAST_SEQ", rd, tv[base+9] & 32'h0000_ffff);
      mode = 0;
      $display("test %0d mode %0d packets %0d: %s", t, tv[base+4], total,
               (test_errs == 0) ? "ok" : "FAILED");
   endtask

   ////////////////////////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////////////////////////
   initial
   begin
      int num_tests;
      int limit;
      clk             = 1'b0;
      rst_n           = 1'b0;
      psel            = 1'b0;
      penable         = 1'b0;
      pwrite          = 1'b0;
      paddr           = '0;
      pwdata          = '0;
      tx_almost_full  = 1'b0;
      rx_data         = '0;
      rx_almost_empty = 1'b1;
      mode            = 0;
      inj_idx         = 0;
      hdr_cnt         = 0;
      hdr_idx         = 0;
      wdx             = 0;
      errors          = 0;
      test_errs       = 0;
      wd_cycles       = 0;
      for (int i = 0; i < MAX_TESTS * FIELDS; i++)
         tv[i] = '0;
      $readmemh("dv/phy_test_patterns.txt", tv);
      num_tests = 0;
      limit     = 2000;
      while (num_tests < MAX_TESTS && tv[num_tests*FIELDS+1] != 0)
      begin
         limit += int'(tv[num_tests*FIELDS+2]) * 4 * (int'(tv[num_tests*FIELDS+1]) + 8);
         limit += DRAIN;
         num_tests++;
      end
      wd_cycles = limit;
      repeat (4) @(posedge clk);
      #1;
      rst_n = 1'b1;
      check_regs();
      for (int t = 0; t < num_tests; t++)
         run_test(t);
      $display("tests run %0d, errors %0d", num_tests + 1, errors);
      if (errors == 0)
         $display("SIMULATION PASSED");
      else
         $display("SIMULATION FAILED");
      $finish;
   end

   // Watchdog sized from the pattern table
   initial
   begin
      wait (wd_cycles > 0);
      repeat (wd_cycles) @(posedge clk);
      $display("Watchdog expired after %0d cycles, the run did not finish", wd_cycles);
      $display("SIMULATION FAILED");
      $finish;
   end

endmodule

/* dv/phy_test_patterns.txt */
// One test per line, all hex: pat_en pkt_words iters init_seq mode pkt_idx
// then expected pass good err last_seq; mode 0 none 1 corrupt 2 drop 3 throttle
// Clean loopback, several masks and sizes
f 10 2 0000 0 0 1 8 0 0007
5 04 3 0100 0 0 1 6 0 0105
8 ff 1 fffe 0 0 1 1 0 fffe
// One corrupted payload word in packet 1
6 08 2 0020 1 1 0 3 1 0023
// Packet 3 dropped, drain timeout ends the run
f 0c 2 0000 2 3 0 6 1 0007
// Random almost_full gaps
f 10 3 0050 3 0 1 c 0 005b
// Shortest packets after an error run
3 02 4 1234 0 0 1 8 0 123b

/* filelist.f */
rtl/phy_test_pkg.sv
rtl/phy_test_ifs.sv
rtl/phy_test_pktsrc.sv
rtl/phy_test_pktcmp.sv
rtl/phy_test_port_ctrl.sv
rtl/phy_test_apb_regs.sv
rtl/phy_test_port_grp.sv
dv/phy_test_assert.sv
dv/phy_test_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the port group testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
   -f filelist.f \
   --top-module phy_test_tb \
   -o sim_phy_test

./obj_dir/sim_phy_test | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
   echo "Run failed, see sim.log"
   exit 1
fi
echo "Run finished without failures"
